// File: source/aceusb_bus_pkg.sv
// External bus geometry shared by the bridge RTL, the device model and the testbench
package aceusb_bus_pkg;

  // ----------------------------------------------------------------------
  // Widths of the shared SystemACE / CY7C67300 bus
  // ----------------------------------------------------------------------

  localparam int ACEUSB_AW = 6;               // Word address lines driven on the bus
  localparam int ACEUSB_DW = 16;              // Data lines shared by both devices

  // ----------------------------------------------------------------------
  // Device selection
  // ----------------------------------------------------------------------

  // The top address bit picks the device that gets a chip select.
  // All address bits still go out on the bus for either device.
  localparam int ACEUSB_SEL_BIT = ACEUSB_AW - 1;  // Set means the USB controller

  // Device identifier as decoded from the select bit
  typedef enum logic {
    DEV_ACE = 1'b0,                           // SystemACE MPU port on ace_mpce_n_o
    DEV_USB = 1'b1                            // CY7C67300 host port on usb_cs_n_o
  } dev_e;

  // Words behind one chip select and across both devices.
  // The device model sizes its storage from these values
  localparam int ACEUSB_DEV_WORDS = 1 << ACEUSB_SEL_BIT;  // Words per device
  localparam int ACEUSB_ALL_WORDS = 1 << ACEUSB_AW;       // Both devices together

  // An idle bus shows no chip select and no strobe
  localparam logic ACEUSB_INACTIVE_N = 1'b1;  // Level of a released active-low line

endpackage

// File: source/aceusb_timing_pkg.sv
// External bus cycle timing, counted in ace_clkin_i cycles, for the sequencer and testbench
package aceusb_timing_pkg;

  // ----------------------------------------------------------------------
  // Phases of one external read or write cycle
  // ----------------------------------------------------------------------

  // Chip select and address settle before the strobe falls
  localparam int ACE_SETUP_CYC = 1;           // Setup cycles before the strobe

  // Output enable or write enable stays low this long.
  // Read data is latched in the last of these cycles
  localparam int ACE_STROBE_CYC = 3;          // Strobe low cycles

  // Chip select, address and write data stay after the strobe rises
  localparam int ACE_HOLD_CYC = 1;            // Hold cycles after the strobe

  // Whole cycle with select asserted, also used to size the testbench timeout
  localparam int ACE_CYCLE_LEN = ACE_SETUP_CYC + ACE_STROBE_CYC + ACE_HOLD_CYC;

endpackage

// File: source/aceusb_sync.sv
// Toggle pulse synchronizer that moves a one-cycle flag from clk0_i into clk1_i
`timescale 1ns/1ps

module aceusb_sync (
  input  logic clk0_i,                        // Source clock
  input  logic flag_i,                        // One-cycle flag in the source domain
  input  logic clk1_i,                        // Destination clock
  output logic flag_o,                        // One-cycle pulse in the destination domain
  input  logic rst_i                          // Synchronous reset, held across both clocks
);

  // ----------------------------------------------------------------------
  // Source side
  // ----------------------------------------------------------------------

  logic       toggle_q;                       // Flips once per source flag
  logic [2:0] sync_q;                         // Destination sampling chain

  always_ff @(posedge clk0_i) begin
    if (rst_i) begin
      toggle_q <= 1'b0;
    end else if (flag_i) begin
      toggle_q <= ~toggle_q;                  // Level change carries the event across
    end
  end

  // ----------------------------------------------------------------------
  // Destination side
  // ----------------------------------------------------------------------

  always_ff @(posedge clk1_i) begin
    if (rst_i) begin
      sync_q <= 3'b000;
    end else begin
      sync_q <= {sync_q[1:0], toggle_q};      // Stage 0 may go metastable and settles here
    end
  end

  // An edge between the last two stages lasts exactly one destination cycle
  assign flag_o = sync_q[2] ^ sync_q[1];

endmodule

// File: source/aceusb_access.sv
// External bus cycle sequencer on ace_clkin_i, instantiated by the aceusb bridge top level
`timescale 1ns/1ps

module aceusb_access
  import aceusb_bus_pkg::*;
  import aceusb_timing_pkg::*;
(
  input  logic                 ace_clkin_i,   // SystemACE clock that paces the bus
  input  logic                 rst_i,         // Bridge reset, longer than a few bus clocks
  input  logic [ACEUSB_AW-1:0] adr_i,         // Captured word address, stable during a cycle
  input  logic [ACEUSB_DW-1:0] dat_i,         // Captured write data, stable during a cycle
  output logic [ACEUSB_DW-1:0] dat_o,         // Read data, held until the next read
  input  logic                 read_i,        // One-cycle read request
  input  logic                 write_i,       // One-cycle write request
  output logic                 ack_o,         // One-cycle pulse when the cycle is over

  output logic [ACEUSB_AW-1:0] aceusb_a_o,    // Shared word address
  inout  wire  [ACEUSB_DW-1:0] aceusb_d_io,   // Shared bidirectional data
  output logic                 aceusb_oe_n_o, // Output enable, low for reads
  output logic                 aceusb_we_n_o, // Write enable, low for writes
  output logic                 ace_mpce_n_o,  // SystemACE chip select
  output logic                 usb_cs_n_o,    // CY7C67300 chip select
  output logic                 usb_hpi_reset_n_o  // USB part reset
);

  // Counter wide enough for the longest phase of a cycle
  localparam int CNT_W = $clog2(ACE_CYCLE_LEN + 1);

  typedef enum logic [1:0] {
    ST_IDLE,                                  // Bus released and waiting for a request
    ST_SETUP,                                 // Select and address valid with strobe high
    ST_STROBE,                                // Output enable or write enable low
    ST_HOLD                                   // Strobe high again and select still low
  } state_t;

  state_t             state_q;                // Sequencer state
  logic [CNT_W-1:0]   cnt_q;                  // Cycles left in the current phase
  logic               wr_q;                   // The running cycle is a write
  logic               ack_q;                  // Registered acknowledge
  logic               drive_q;                // Bridge owns the data bus
  logic               oe_n_q;                 // Registered output enable
  logic               we_n_q;                 // Registered write enable
  logic               ace_cs_n_q;             // Registered SystemACE select
  logic               usb_cs_n_q;             // Registered USB select
  logic [ACEUSB_DW-1:0] rd_dat_q;             // Read data latch
  dev_e               req_dev;                // Device addressed by the request

  assign req_dev = dev_e'(adr_i[ACEUSB_SEL_BIT]);  // Select bit decodes straight to a device

  // ----------------------------------------------------------------------
  // Cycle sequencer
  // ----------------------------------------------------------------------

  // All bus controls come from flops so that no decode glitch reaches a pin
  always_ff @(posedge ace_clkin_i) begin
    if (rst_i) begin
      state_q    <= ST_IDLE;
      cnt_q      <= '0;
      wr_q       <= 1'b0;
      ack_q      <= 1'b0;
      drive_q    <= 1'b0;
      oe_n_q     <= ACEUSB_INACTIVE_N;
      we_n_q     <= ACEUSB_INACTIVE_N;
      ace_cs_n_q <= ACEUSB_INACTIVE_N;
      usb_cs_n_q <= ACEUSB_INACTIVE_N;
    end else begin
      ack_q <= 1'b0;                          // Acknowledge lasts a single cycle
      case (state_q)
        ST_IDLE: begin
          if (read_i || write_i) begin
            state_q    <= ST_SETUP;
            cnt_q      <= CNT_W'(ACE_SETUP_CYC - 1);
            wr_q       <= write_i;
            drive_q    <= write_i;            // Write data goes out together with the select
            ace_cs_n_q <= (req_dev != DEV_ACE);
            usb_cs_n_q <= (req_dev != DEV_USB);
          end
        end
        ST_SETUP: begin
          if (cnt_q == '0) begin
            state_q <= ST_STROBE;
            cnt_q   <= CNT_W'(ACE_STROBE_CYC - 1);
            oe_n_q  <= wr_q;                  // Reads pull output enable low
            we_n_q  <= ~wr_q;                 // Writes pull write enable low
          end else begin
            cnt_q <= cnt_q - 1'b1;
          end
        end
        ST_STROBE: begin
          if (cnt_q == '0) begin
            state_q <= ST_HOLD;
            cnt_q   <= CNT_W'(ACE_HOLD_CYC - 1);
            oe_n_q  <= ACEUSB_INACTIVE_N;     // Rising write enable is the device store edge
            we_n_q  <= ACEUSB_INACTIVE_N;
          end else begin
            cnt_q <= cnt_q - 1'b1;
          end
        end
        ST_HOLD: begin
          if (cnt_q == '0) begin
            state_q    <= ST_IDLE;
            ack_q      <= 1'b1;
            drive_q    <= 1'b0;               // Release the data bus at the end of hold
            ace_cs_n_q <= ACEUSB_INACTIVE_N;
            usb_cs_n_q <= ACEUSB_INACTIVE_N;
          end else begin
            cnt_q <= cnt_q - 1'b1;
          end
        end
        default: begin
          state_q <= ST_IDLE;
        end
      endcase
    end
  end

  // Sample the device in the last strobe cycle while its output is still enabled
  always_ff @(posedge ace_clkin_i) begin
    if (state_q == ST_STROBE && cnt_q == '0 && !wr_q) begin
      rd_dat_q <= aceusb_d_io;
    end
  end

  // ----------------------------------------------------------------------
  // Outputs
  // ----------------------------------------------------------------------

  assign aceusb_a_o        = adr_i;           // Held by the capture register in the top level
  assign aceusb_d_io       = drive_q ? dat_i : {ACEUSB_DW{1'bz}};
  assign aceusb_oe_n_o     = oe_n_q;
  assign aceusb_we_n_o     = we_n_q;
  assign ace_mpce_n_o      = ace_cs_n_q;
  assign usb_cs_n_o        = usb_cs_n_q;
  assign usb_hpi_reset_n_o = ~rst_i;          // USB part stays in reset with the bridge
  assign dat_o             = rd_dat_q;
  assign ack_o             = ack_q;

endmodule

// File: source/aceusb.sv
// Wishbone to SystemACE and CY7C67300 bridge top level, placed as a 16-bit Wishbone slave
`timescale 1ns/1ps

module aceusb
  import aceusb_bus_pkg::*;
(
  // Wishbone slave side
  input  logic                 wb_clk_i,      // Wishbone clock
  input  logic                 wb_rst_i,      // Synchronous reset, active high
  input  logic [ACEUSB_AW-1:0] wb_adr_i,      // Word address with the device select on top
  input  logic [ACEUSB_DW-1:0] wb_dat_i,      // Write data
  output logic [ACEUSB_DW-1:0] wb_dat_o,      // Read data, valid with wb_ack_o
  input  logic                 wb_cyc_i,      // Bus cycle in progress
  input  logic                 wb_stb_i,      // Strobe for this slave
  input  logic                 wb_we_i,       // Write when set
  output logic                 wb_ack_o,      // One-cycle acknowledge

  // Bus shared by SystemACE and USB
  output logic [ACEUSB_AW-1:0] aceusb_a_o,    // Word address
  inout  wire  [ACEUSB_DW-1:0] aceusb_d_io,   // Bidirectional data
  output logic                 aceusb_oe_n_o, // Output enable
  output logic                 aceusb_we_n_o, // Write enable

  // Device specific pins
  input  logic                 ace_clkin_i,   // SystemACE clock that times the bus
  output logic                 ace_mpce_n_o,  // SystemACE chip select
  output logic                 usb_cs_n_o,    // CY7C67300 chip select
  output logic                 usb_hpi_reset_n_o  // CY7C67300 reset
);

  typedef enum logic {
    S_IDLE,                                   // Ready for a new request
    S_WAIT                                    // External cycle in flight
  } wb_state_t;

  wb_state_t            state_q;              // Current FSM state
  wb_state_t            state_d;              // Next FSM state
  logic                 op;                   // Active request from the master
  logic                 load;                 // Capture address and data this cycle
  logic                 rd_flag;              // Read request in the Wishbone domain
  logic                 wr_flag;              // Write request in the Wishbone domain
  logic                 ace_rd;               // Read request in the bus domain
  logic                 ace_wr;               // Write request in the bus domain
  logic                 ace_ack;              // Cycle done in the bus domain
  logic                 wb_done;              // Cycle done back in the Wishbone domain
  logic [ACEUSB_AW-1:0] adr_q;                // Captured address
  logic [ACEUSB_DW-1:0] dat_q;                // Captured write data

  // ----------------------------------------------------------------------
  // Request capture
  // ----------------------------------------------------------------------

  // Master-side changes after the first cycle never reach the external bus
  always_ff @(posedge wb_clk_i) begin
    if (load) begin
      adr_q <= wb_adr_i;
      dat_q <= wb_dat_i;
    end
  end

  // ----------------------------------------------------------------------
  // Wishbone FSM
  // ----------------------------------------------------------------------

  assign op = wb_cyc_i & wb_stb_i;

  always_ff @(posedge wb_clk_i) begin
    if (wb_rst_i) begin
      state_q <= S_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  always_comb begin
    state_d  = state_q;
    load     = 1'b0;
    rd_flag  = 1'b0;
    wr_flag  = 1'b0;
    wb_ack_o = 1'b0;
    case (state_q)
      S_IDLE: begin
        if (op) begin
          load    = 1'b1;                     // Entry cycle of the request
          rd_flag = ~wb_we_i;
          wr_flag = wb_we_i;
          state_d = S_WAIT;
        end
      end
      S_WAIT: begin
        if (wb_done) begin
          wb_ack_o = 1'b1;                    // Read data has been stable since the latch
          state_d  = S_IDLE;
        end
      end
      default: begin
        state_d = S_IDLE;
      end
    endcase
  end

  // ----------------------------------------------------------------------
  // Clock domain crossings and the bus sequencer
  // ----------------------------------------------------------------------

  aceusb_sync sync_rd (
    .clk0_i (wb_clk_i),
    .flag_i (rd_flag),
    .clk1_i (ace_clkin_i),
    .flag_o (ace_rd),
    .rst_i  (wb_rst_i)
  );

  aceusb_sync sync_wr (
    .clk0_i (wb_clk_i),
    .flag_i (wr_flag),
    .clk1_i (ace_clkin_i),
    .flag_o (ace_wr),
    .rst_i  (wb_rst_i)
  );

  aceusb_sync sync_ack (
    .clk0_i (ace_clkin_i),
    .flag_i (ace_ack),
    .clk1_i (wb_clk_i),
    .flag_o (wb_done),
    .rst_i  (wb_rst_i)
  );

  aceusb_access access (
    .ace_clkin_i       (ace_clkin_i),
    .rst_i             (wb_rst_i),
    .adr_i             (adr_q),
    .dat_i             (dat_q),
    .dat_o             (wb_dat_o),
    .read_i            (ace_rd),
    .write_i           (ace_wr),
    .ack_o             (ace_ack),
    .aceusb_a_o        (aceusb_a_o),
    .aceusb_d_io       (aceusb_d_io),
    .aceusb_oe_n_o     (aceusb_oe_n_o),
    .aceusb_we_n_o     (aceusb_we_n_o),
    .ace_mpce_n_o      (ace_mpce_n_o),
    .usb_cs_n_o        (usb_cs_n_o),
    .usb_hpi_reset_n_o (usb_hpi_reset_n_o)
  );

endmodule

// File: tests/ace_dev_model.sv
// Behavioral model of the SystemACE and CY7C67300 registers, hung on the bridge bus by the testbench
`timescale 1ns/1ps

module ace_dev_model
  import aceusb_bus_pkg::*;
(
  input  logic [ACEUSB_AW-1:0] a_i,           // Word address from the bridge
  inout  wire  [ACEUSB_DW-1:0] d_io,          // Shared data bus
  input  logic                 oe_n_i,        // Output enable, low while the bridge reads
  input  logic                 we_n_i,        // Write enable, the word is stored as it rises
  input  logic                 ace_cs_n_i,    // SystemACE chip select
  input  logic                 usb_cs_n_i     // CY7C67300 chip select
);

  logic [ACEUSB_DW-1:0] mem [ACEUSB_ALL_WORDS];  // ACE words low, USB words in the upper half
  logic                 sel;                  // Either device selected
  dev_e                 dev;                  // Device that owns the access
  logic [ACEUSB_AW-1:0] idx;                  // Word index across both devices

  // The chip select, not the address, decides which half is used
  assign sel = ~ace_cs_n_i | ~usb_cs_n_i;
  assign dev = usb_cs_n_i ? DEV_ACE : DEV_USB;
  assign idx = {logic'(dev), a_i[ACEUSB_SEL_BIT-1:0]};

  // Power-on contents, each word a product of its index with the index rotated on top
  function automatic logic [ACEUSB_DW-1:0] power_on_word(input logic [ACEUSB_AW-1:0] i);
    logic [ACEUSB_DW-1:0] w;
    w = {{(ACEUSB_DW-ACEUSB_AW){1'b0}}, i};
    return (w * 16'h2c9b) ^ {w[ACEUSB_AW-1:0], w[ACEUSB_DW-1:ACEUSB_AW]};  // Rotate right
  endfunction

  // ----------------------------------------------------------------------
  // Storage
  // ----------------------------------------------------------------------

  initial begin
    for (int k = 0; k < ACEUSB_ALL_WORDS; k++) begin
      mem[k] = power_on_word(ACEUSB_AW'(k));  // Every address gets its own pattern
    end
  end

  // Write data is held by the bridge through the hold phase, past this edge
  always @(posedge we_n_i) begin
    if (sel) begin
      mem[idx] = d_io;
    end
  end

  // ----------------------------------------------------------------------
  // Read drive
  // ----------------------------------------------------------------------

  assign d_io = (sel && !oe_n_i) ? mem[idx] : {ACEUSB_DW{1'bz}};  // Released otherwise

endmodule

// File: tests/aceusb_sva.sv
// Bus protocol and Wishbone acknowledge assertions, bound into every aceusb instance
`timescale 1ns/1ps

module aceusb_sva (
  input logic wb_clk_i,                       // Wishbone clock
  input logic wb_rst_i,                       // Bridge reset, checks are off while high
  input logic wb_cyc_i,                       // Master cycle
  input logic wb_stb_i,                       // Master strobe
  input logic wb_ack_i,                       // Slave acknowledge
  input logic ace_clkin_i,                    // Bus clock
  input logic ace_cs_n_i,                     // SystemACE chip select
  input logic usb_cs_n_i,                     // USB chip select
  input logic oe_n_i,                         // Output enable
  input logic we_n_i                          // Write enable
);

  // Bus pins only move on ace_clkin_i so that clock sees every state
  cs_exclusive: assert property (@(posedge ace_clkin_i) disable iff (wb_rst_i)
    ace_cs_n_i || usb_cs_n_i)
    else $error("Both chip selects low on the shared bus");

  strobe_exclusive: assert property (@(posedge ace_clkin_i) disable iff (wb_rst_i)
    oe_n_i || we_n_i)
    else $error("Output enable and write enable low together");

  ack_in_request: assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
    wb_ack_i |-> (wb_cyc_i && wb_stb_i))
    else $error("Acknowledge outside an active request");

  ack_one_cycle: assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
    wb_ack_i |=> !wb_ack_i)
    else $error("Acknowledge high for two cycles in a row");

endmodule

bind aceusb aceusb_sva sva (
  .wb_clk_i    (wb_clk_i),
  .wb_rst_i    (wb_rst_i),
  .wb_cyc_i    (wb_cyc_i),
  .wb_stb_i    (wb_stb_i),
  .wb_ack_i    (wb_ack_o),
  .ace_clkin_i (ace_clkin_i),
  .ace_cs_n_i  (ace_mpce_n_o),
  .usb_cs_n_i  (usb_cs_n_o),
  .oe_n_i      (aceusb_oe_n_o),
  .we_n_i      (aceusb_we_n_o)
);

// File: tests/tb_aceusb.sv
// Testbench for the aceusb bridge with a device model on the external bus, run as the top module
`timescale 1ns/1ps

module tb_aceusb
  import aceusb_bus_pkg::*;
  import aceusb_timing_pkg::*;
();

  localparam int RST_CYC   = 16;              // Reset length in wb_clk_i cycles
  localparam int CLK_RATIO = 3;               // ace_clkin_i period over wb_clk_i period
  localparam int N_DIR     = 4;               // Words per device in the directed tests
  localparam int N_UNW     = 8;               // Reads of never written words
  localparam int N_RAND    = 200;             // Random mix length
  localparam int N_TXN     = 5 * N_DIR + N_UNW + N_RAND + 2;
  localparam int TIMEOUT_CYC = RST_CYC + N_TXN * (ACE_CYCLE_LEN + 8) * CLK_RATIO * 2;

  typedef struct packed {
    logic                 rd;                 // Read that needs a data check
    logic [ACEUSB_AW-1:0] adr;
    logic [ACEUSB_DW-1:0] val;                // Expected read data
  } txn_t;

  logic                 wb_clk_i, wb_rst_i, wb_cyc_i, wb_stb_i, wb_we_i, wb_ack_o;
  logic [ACEUSB_AW-1:0] wb_adr_i, aceusb_a_o;
  logic [ACEUSB_DW-1:0] wb_dat_i, wb_dat_o;
  wire  [ACEUSB_DW-1:0] aceusb_d_io;          // Driven by the bridge or the model
  logic                 aceusb_oe_n_o, aceusb_we_n_o, ace_clkin_i;
  logic                 ace_mpce_n_o, usb_cs_n_o, usb_hpi_reset_n_o;

  logic [ACEUSB_DW-1:0] ref_mem [ACEUSB_ALL_WORDS];  // Last value written per address
  logic                 ref_wr  [ACEUSB_ALL_WORDS];  // Address has been written
  txn_t                 pending_q [$];        // Requests still waiting for their acknowledge
  logic [31:0]          lcg_q = 32'd34;
  int                   err_cnt = 0, chk_cnt = 0, req_cnt = 0, ack_cnt = 0, cyc_cnt = 0;

  aceusb DUT (.*);

  ace_dev_model dev_model (
    .a_i (aceusb_a_o), .d_io (aceusb_d_io), .oe_n_i (aceusb_oe_n_o),
    .we_n_i (aceusb_we_n_o), .ace_cs_n_i (ace_mpce_n_o), .usb_cs_n_i (usb_cs_n_o)
  );

  initial begin
    wb_clk_i = 1'b0;
    forever #5 wb_clk_i = ~wb_clk_i;          // 10 ns Wishbone clock
  end

  initial begin
    ace_clkin_i = 1'b0;
    forever #15 ace_clkin_i = ~ace_clkin_i;   // Three times slower bus clock
  end

  // ----------------------------------------------------------------------
  // Reference model, random source and checks
  // ----------------------------------------------------------------------

  function automatic logic [31:0] lcg_step(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // Expected read data is the last write or else the power-on word of the device
  function automatic logic [ACEUSB_DW-1:0] ref_read(input logic [ACEUSB_AW-1:0] adr);
    logic [ACEUSB_DW-1:0] idx;
    idx = 16'(adr);
    if (ref_wr[adr]) return ref_mem[adr];
    return (idx * 16'h2c9b) ^ {adr, 10'h000};
  endfunction

  task automatic compare_val(input string name, input logic [15:0] got, input logic [15:0] exp);
    chk_cnt++;
    if (got !== exp) begin
      $display("MISMATCH at %0t ns: %s = %h, expected %h", $time, name, got, exp);
      err_cnt++;
    end
  endtask

  // Idle pins of the bridge, with the USB reset level depending on the reset phase
  task automatic check_idle_pins(input logic hpi_exp);
    compare_val("wb_ack_o", 16'(wb_ack_o), 16'h0);
    compare_val("ace_mpce_n_o", 16'(ace_mpce_n_o), 16'h1);
    compare_val("usb_cs_n_o", 16'(usb_cs_n_o), 16'h1);
    compare_val("aceusb_oe_n_o", 16'(aceusb_oe_n_o), 16'h1);
    compare_val("aceusb_we_n_o", 16'(aceusb_we_n_o), 16'h1);
    compare_val("usb_hpi_reset_n_o", 16'(usb_hpi_reset_n_o), 16'(hpi_exp));
  endtask

  task automatic report_test(input string name, input int errs_before);
    if (err_cnt == errs_before) $display("Test %s: ok", name);
    else $display("Test %s: %0d errors", name, err_cnt - errs_before);
  endtask

  // Every acknowledge retires the oldest request and checks read data
  always @(negedge wb_clk_i) begin : check_ack
    txn_t t;
    // A selected device sees the full address of the request in flight
    if ((!ace_mpce_n_o || !usb_cs_n_o) && pending_q.size() != 0) begin
      compare_val("aceusb_a_o", 16'(aceusb_a_o), 16'(pending_q[0].adr));
      compare_val("usb_cs_n_o", 16'(usb_cs_n_o), 16'(!pending_q[0].adr[ACEUSB_SEL_BIT]));
    end
    if (wb_ack_o) begin
      ack_cnt++;
      if (pending_q.size() == 0) begin
        $display("Acknowledge at %0t ns with no request outstanding", $time);
        err_cnt++;
      end else begin
        t = pending_q.pop_front();
        if (t.rd) compare_val("wb_dat_o", wb_dat_o, t.val);
      end
    end
  end

  // ----------------------------------------------------------------------
  // Wishbone master
  // ----------------------------------------------------------------------

  // Request held until the acknowledge, optionally with the write data changed after capture
  task automatic wb_access(input logic we, input logic [ACEUSB_AW-1:0] adr,
                           input logic [ACEUSB_DW-1:0] dat, input logic alter);
    txn_t t;
    @(negedge wb_clk_i);
    t.rd  = ~we;
    t.adr = adr;
    t.val = ref_read(adr);
    if (we) begin
      ref_mem[adr] = dat;
      ref_wr[adr]  = 1'b1;
    end
    pending_q.push_back(t);
    req_cnt++;
    {wb_cyc_i, wb_stb_i, wb_we_i, wb_adr_i, wb_dat_i} = {1'b1, 1'b1, we, adr, dat};
    if (alter) begin
      @(negedge wb_clk_i);
      wb_dat_i = ~dat;                        // The bridge captured dat one edge ago
    end
    do @(negedge wb_clk_i); while (!wb_ack_o);
  endtask

  task automatic bus_idle();
    @(negedge wb_clk_i);
    {wb_cyc_i, wb_stb_i, wb_we_i} = 3'b000;
  endtask

  initial begin : watchdog
    while (cyc_cnt < TIMEOUT_CYC) begin
      @(posedge wb_clk_i);
      cyc_cnt++;
    end
    $display("Timeout after %0d cycles, the run hung without an acknowledge", cyc_cnt);
    $display("*** TEST FAILED ***");
    $finish;
  end

  initial begin : main
    int e0, r0, a0;
    logic [ACEUSB_AW-1:0] adr;
    {wb_rst_i, wb_cyc_i, wb_stb_i, wb_we_i, wb_adr_i, wb_dat_i} = {4'b1000, 6'h0, 16'h0};
    for (int k = 0; k < ACEUSB_ALL_WORDS; k++) ref_wr[k] = 1'b0;
    e0 = err_cnt;
    repeat (RST_CYC / 2) @(negedge wb_clk_i);
    check_idle_pins(1'b0);                    // Midway through reset
    repeat (RST_CYC - RST_CYC / 2) @(negedge wb_clk_i);
    wb_rst_i = 1'b0;
    @(negedge wb_clk_i);
    check_idle_pins(1'b1);
    report_test("reset state", e0);

    e0 = err_cnt;
    for (int i = 0; i < N_DIR; i++) begin
      lcg_q = lcg_step(lcg_q);
      wb_access(1'b1, ACEUSB_AW'(i * 9), lcg_q[31:16], 1'b0);  // Select bit clear
    end
    for (int i = 0; i < N_DIR; i++) wb_access(1'b0, ACEUSB_AW'(i * 9), 16'h0, 1'b0);
    bus_idle();
    for (int i = 0; i < N_DIR; i++) begin
      adr = ACEUSB_AW'(i * 9);
      compare_val("model ACE word", dev_model.mem[adr], ref_mem[adr]);
    end
    report_test("ACE write and read back", e0);

    e0 = err_cnt;
    for (int i = 0; i < N_DIR; i++) begin
      lcg_q = lcg_step(lcg_q);
      wb_access(1'b1, ACEUSB_AW'(i * 9 + ACEUSB_DEV_WORDS), lcg_q[31:16], 1'b0);
    end
    for (int i = 0; i < N_DIR; i++) begin
      wb_access(1'b0, ACEUSB_AW'(i * 9 + ACEUSB_DEV_WORDS), 16'h0, 1'b0);
      wb_access(1'b0, ACEUSB_AW'(i * 9), 16'h0, 1'b0);  // Same low bits on the ACE side
    end
    bus_idle();
    for (int i = 0; i < N_DIR; i++) begin
      adr = ACEUSB_AW'(i * 9 + ACEUSB_DEV_WORDS);
      compare_val("model USB word", dev_model.mem[adr], ref_mem[adr]);
    end
    report_test("USB write and read back", e0);

    e0 = err_cnt;
    for (int i = 0; i < N_UNW; i++) begin
      wb_access(1'b0, ACEUSB_AW'((i % 4) * 9 + 4 + (i / 4) * ACEUSB_DEV_WORDS), 16'h0, 1'b0);
    end
    bus_idle();
    report_test("unwritten reads", e0);

    e0 = err_cnt;
    r0 = req_cnt;
    a0 = ack_cnt;
    for (int i = 0; i < N_RAND; i++) begin
      lcg_q = lcg_step(lcg_q);
      wb_access(lcg_q[27], lcg_q[13:8], lcg_q[31:16], 1'b0);  // Back to back, no idle
    end
    bus_idle();
    compare_val("acknowledge count", 16'(ack_cnt - a0), 16'(req_cnt - r0));
    report_test("random mix", e0);

    e0 = err_cnt;
    wb_access(1'b1, 6'h07, 16'ha5c3, 1'b1);
    wb_access(1'b0, 6'h07, 16'h0, 1'b0);
    bus_idle();
    compare_val("model held word", dev_model.mem[6'h07], 16'ha5c3);
    report_test("held request", e0);

    if (pending_q.size() != 0) begin
      $display("%0d requests never received an acknowledge", pending_q.size());
      err_cnt++;
    end
    $display("Done: %0d checks, %0d errors, %0d requests, %0d acknowledges",
             chk_cnt, err_cnt, req_cnt, ack_cnt);
    if (err_cnt == 0) $display("*** TEST PASSED ***");
    else $display("*** TEST FAILED ***");
    $finish;
  end

endmodule

// File: sim.f
source/aceusb_bus_pkg.sv
source/aceusb_timing_pkg.sv
source/aceusb_sync.sv
source/aceusb_access.sv
source/aceusb.sv
tests/ace_dev_model.sv
tests/aceusb_sva.sv
tests/tb_aceusb.sv

// File: Makefile
# Verilator flow for the aceusb bridge: lint, build and run, clean

VERILATOR ?= verilator
TOP       ?= tb_aceusb
RTL_TOP   ?= aceusb
FILELIST  ?= sim.f
OBJ_DIR   ?= obj_dir
JOBS      ?= 0
VFLAGS    ?= --timing --assert
RTL_SRCS  ?= source/aceusb_bus_pkg.sv source/aceusb_timing_pkg.sv \
             source/aceusb_sync.sv source/aceusb_access.sv source/aceusb.sv
PASS_MSG  := *** TEST PASSED ***

.PHONY: all lint sim clean

all: sim

# RTL on its own, then the full testbench
lint:
	$(VERILATOR) --lint-only --top-module $(RTL_TOP) $(RTL_SRCS)
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

# Build, run, and pass only if the pass message shows up in the output
sim:
	$(VERILATOR) --binary $(VFLAGS) -j $(JOBS) --top-module $(TOP) \
		--Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF '$(PASS_MSG)'

clean:
	rm -rf $(OBJ_DIR)
